// ==== hw/cpuPkg.sv ====
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm_t;

    parameter word_t ResetVector = 32'hBFC00000;

    // Primary opcodes
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opSb      = 6'b101000,
        opSw      = 6'b101011
    } opcode_t;

    // Function field of R-type
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } func_t;

    typedef enum logic [4:0] {
        rtBltz = 5'b00000,
        rtBgez = 5'b00001
    } regimmOp_t;

    typedef enum logic [2:0] {
        fetchSt     = 3'd0,
        decodeSt    = 3'd1,
        execSt      = 3'd2,
        memSt       = 3'd3,
        writeBackSt = 3'd4,
        haltedSt    = 3'd7
    } cpuState_t;

    typedef enum logic [3:0] {
        aluAnd, aluOr, aluXor, aluAdd, aluSub, aluSlt, aluSltu, aluSll,
        aluSrl, aluSra, aluSllv, aluSrlv, aluSrav, aluLui, aluPassA
    } aluOp_t;

    typedef enum logic [3:0] {
        brNone, brEq, brNe, brLez, brGtz, brGez, brLtz, brJump, brJumpReg
    } branchKind_t;

    typedef struct packed {
        aluOp_t      aluOp;
        logic        useImm;
        logic        zeroExtImm;
        logic        regWrite;
        regAddr_t    destReg;
        logic        memRead;
        logic        memWrite;
        logic        byteAccess;
        logic        loadUnsigned;
        branchKind_t branchKind;
        shamt_t      shamt;
    } decodedCtrl_t;

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  logic            decodePhase,
    input  cpuPkg::regAddr_t rdAddrA,
    input  cpuPkg::regAddr_t rdAddrB,
    input  logic            wrEn,
    input  cpuPkg::regAddr_t wrAddr,
    input  cpuPkg::word_t    wrData,
    output cpuPkg::word_t    rdDataA,
    output cpuPkg::word_t    rdDataB,
    output cpuPkg::word_t    registerV0
);
    import cpuPkg::*;

    word_t regs [32];

    // All registers clear on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Operands held from decode through write-back
    always_ff @(posedge clk) begin
        if (decodePhase) begin
            rdDataA <= (rdAddrA == '0) ? '0 : regs[rdAddrA];
            rdDataB <= (rdAddrB == '0) ? '0 : regs[rdAddrB];
        end
    end

    assign registerV0 = regs[2];

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  cpuPkg::aluOp_t op,
    input  cpuPkg::word_t  a,
    input  cpuPkg::word_t  b,
    input  cpuPkg::shamt_t shamt,
    output cpuPkg::word_t  result,
    output logic           zero
);
    import cpuPkg::*;

    shamt_t varShift;

    // Variable shifts take the amount from rs
    assign varShift = a[4:0];

    always_comb begin
        case (op)
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluXor: begin
                result = a ^ b;
            end
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluSlt: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            aluSltu: begin
                result = {31'b0, a < b};
            end
            aluSll:  result = b << shamt;
            aluSrl:  result = b >> shamt;
            aluSra:  result = word_t'($signed(b) >>> shamt);
            aluSllv: result = b << varShift;
            aluSrlv: result = b >> varShift;
            aluSrav: result = word_t'($signed(b) >>> varShift);
            aluLui: begin
                result = {b[15:0], 16'b0};
            end
            // Compare-with-zero branches look at rs itself
            aluPassA: result = a;
            default:  result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 decodePhase,
    input  cpuPkg::word_t        readdata,
    output cpuPkg::decodedCtrl_t ctrl,
    output cpuPkg::word_t        immExt,
    output logic [25:0]          jumpIndex
);
    import cpuPkg::*;

    decodedCtrl_t next;
    imm_t         imm;

    assign imm = readdata[15:0];

    always_comb begin
        next = '0;
        next.shamt = readdata[10:6];
        // I-type writes rt
        next.destReg = readdata[20:16];
        case (opcode_t'(readdata[31:26]))
            opSpecial: begin
                next.destReg = readdata[15:11];
                next.regWrite = 1'b1;
                case (func_t'(readdata[5:0]))
                    fnSll:  next.aluOp = aluSll;
                    fnSrl:  next.aluOp = aluSrl;
                    fnSra:  next.aluOp = aluSra;
                    fnSllv: next.aluOp = aluSllv;
                    fnSrlv: next.aluOp = aluSrlv;
                    fnSrav: next.aluOp = aluSrav;
                    fnAddu: next.aluOp = aluAdd;
                    fnSubu: next.aluOp = aluSub;
                    fnAnd:  next.aluOp = aluAnd;
                    fnOr:   next.aluOp = aluOr;
                    fnXor:  next.aluOp = aluXor;
                    fnSlt:  next.aluOp = aluSlt;
                    fnSltu: next.aluOp = aluSltu;
                    fnJr: begin
                        next.regWrite = 1'b0;
                        next.branchKind = brJumpReg;
                    end
                    default: next.regWrite = 1'b0;
                endcase
            end
            opRegimm: begin
                next.aluOp = aluPassA;
                case (regimmOp_t'(readdata[20:16]))
                    rtBgez:  next.branchKind = brGez;
                    rtBltz:  next.branchKind = brLtz;
                    default: next.branchKind = brNone;
                endcase
            end
            opJ: next.branchKind = brJump;
            opBeq: begin
                next.aluOp = aluSub;
                next.branchKind = brEq;
            end
            opBne: begin
                next.aluOp = aluSub;
                next.branchKind = brNe;
            end
            opBlez: begin
                next.aluOp = aluPassA;
                next.branchKind = brLez;
            end
            opBgtz: begin
                next.aluOp = aluPassA;
                next.branchKind = brGtz;
            end
            opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                next.useImm = 1'b1;
                next.regWrite = 1'b1;
                case (opcode_t'(readdata[31:26]))
                    opSlti:  next.aluOp = aluSlt;
                    opSltiu: next.aluOp = aluSltu;
                    opAndi:  next.aluOp = aluAnd;
                    opOri:   next.aluOp = aluOr;
                    opXori:  next.aluOp = aluXor;
                    opLui:   next.aluOp = aluLui;
                    default: next.aluOp = aluAdd;
                endcase
                next.zeroExtImm = next.aluOp inside {aluAnd, aluOr, aluXor};
            end
            opLb, opLbu, opLw: begin
                next.aluOp = aluAdd;
                next.useImm = 1'b1;
                next.regWrite = 1'b1;
                next.memRead = 1'b1;
                next.byteAccess = (readdata[31:26] != opLw);
                next.loadUnsigned = (readdata[31:26] == opLbu);
            end
            opSb, opSw: begin
                next.aluOp = aluAdd;
                next.useImm = 1'b1;
                next.memWrite = 1'b1;
                next.byteAccess = (readdata[31:26] == opSb);
            end
            default: next = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl <= '0;
        end else if (decodePhase) begin
            ctrl <= next;
        end
    end

    always_ff @(posedge clk) begin
        if (decodePhase) begin
            immExt <= next.zeroExtImm ? {16'b0, imm} : {{16{imm[15]}}, imm};
            jumpIndex <= readdata[25:0];
        end
    end

endmodule

// ==== hw/loadStore.sv ====
`timescale 1ns/100ps

module loadStore (
    input  logic                 fetchPhase,
    input  logic                 memPhase,
    input  cpuPkg::decodedCtrl_t ctrl,
    input  cpuPkg::word_t        pc,
    input  cpuPkg::word_t        aluResult,
    input  cpuPkg::word_t        storeData,
    input  cpuPkg::word_t        readdata,
    output cpuPkg::word_t        address,
    output cpuPkg::word_t        writedata,
    output cpuPkg::word_t        loadData,
    output cpuPkg::byteEn_t      byteenable,
    output logic                 read,
    output logic                 write
);
    import cpuPkg::*;

    word_t      rawAddr;
    logic [1:0] lane;
    logic [7:0] loadByte;

    assign rawAddr = fetchPhase ? pc : aluResult;
    assign address = {rawAddr[31:2], 2'b00};
    assign lane = aluResult[1:0];

    assign read = fetchPhase || (memPhase && ctrl.memRead);
    assign write = memPhase && ctrl.memWrite;

    // Byte lanes only narrow for byte accesses in the memory phase
    always_comb begin
        if (memPhase && ctrl.byteAccess) begin
            byteenable = byteEn_t'(4'b0001 << lane);
        end else begin
            byteenable = 4'b1111;
        end
    end

    // SB puts the byte on every lane and lets byteenable pick one
    assign writedata = ctrl.byteAccess ? {4{storeData[7:0]}} : storeData;

    assign loadByte = readdata[8*lane +: 8];

    always_comb begin
        if (!ctrl.byteAccess) begin
            loadData = readdata;
        end else if (ctrl.loadUnsigned) begin
            loadData = {24'b0, loadByte};
        end else begin
            loadData = {{24{loadByte[7]}}, loadByte};
        end
    end

endmodule

// ==== hw/cpuControl.sv ====
`timescale 1ns/100ps

module cpuControl #(
    parameter cpuPkg::word_t resetVector = cpuPkg::ResetVector
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  cpuPkg::decodedCtrl_t ctrl,
    input  cpuPkg::word_t        immExt,
    input  logic [25:0]          jumpIndex,
    input  cpuPkg::word_t        rdDataA,
    input  cpuPkg::word_t        aluResult,
    input  logic                 aluZero,
    input  cpuPkg::word_t        loadData,
    output cpuPkg::word_t        pc,
    output logic                 fetchPhase,
    output logic                 decodePhase,
    output logic                 memPhase,
    output logic                 wbStrobe,
    output cpuPkg::word_t        wbData,
    output logic                 active
);
    import cpuPkg::*;

    cpuState_t state;
    word_t     pcPlus4;
    word_t     branchTarget;
    word_t     target;
    word_t     loadHold;
    logic      memAccess;
    logic      takeBranch;
    // Taken branch waiting for its delay slot, then target due next
    logic      branchTaken;
    logic      jumpNext;

    assign pcPlus4 = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign memAccess = ctrl.memRead || ctrl.memWrite;

    // Address zero halts instead of being fetched
    assign fetchPhase = (state == fetchSt) && (pc != '0);
    assign decodePhase = (state == decodeSt);
    assign memPhase = (state == memSt);
    assign wbStrobe = (state == writeBackSt) && ctrl.regWrite;
    assign wbData = ctrl.memRead ? loadHold : aluResult;

    always_comb begin
        case (ctrl.branchKind)
            brEq:    takeBranch = aluZero;
            brNe:    takeBranch = !aluZero;
            brLez:   takeBranch = aluResult[31] || aluZero;
            brGtz:   takeBranch = !aluResult[31] && !aluZero;
            brGez:   takeBranch = !aluResult[31];
            brLtz:   takeBranch = aluResult[31];
            default: takeBranch = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fetchSt;
            pc <= resetVector;
            active <= 1'b1;
            branchTaken <= 1'b0;
            jumpNext <= 1'b0;
        end else begin
            case (state)
                fetchSt: begin
                    if (pc == '0) begin
                        active <= 1'b0;
                        state <= haltedSt;
                    end else if (!waitrequest) begin
                        state <= decodeSt;
                    end
                end
                decodeSt: state <= execSt;
                execSt: begin
                    if (ctrl.branchKind == brJump) begin
                        branchTaken <= 1'b1;
                        target <= {pcPlus4[31:28], jumpIndex, 2'b00};
                    end else if (ctrl.branchKind == brJumpReg) begin
                        branchTaken <= 1'b1;
                        target <= rdDataA;
                    end
                    state <= memSt;
                end
                memSt: begin
                    if (takeBranch) begin
                        branchTaken <= 1'b1;
                        target <= branchTarget;
                    end
                    if (!(memAccess && waitrequest)) begin
                        state <= writeBackSt;
                    end
                end
                writeBackSt: begin
                    // Delay slot runs first, then the saved target
                    if (branchTaken) begin
                        branchTaken <= 1'b0;
                        jumpNext <= 1'b1;
                        pc <= pcPlus4;
                    end else if (jumpNext) begin
                        jumpNext <= 1'b0;
                        pc <= target;
                    end else begin
                        pc <= pcPlus4;
                    end
                    state <= fetchSt;
                end
                default: state <= haltedSt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (memPhase && !waitrequest) begin
            loadHold <= loadData;
        end
    end

endmodule

// ==== hw/mipsCpuBus.sv ====
`timescale 1ns/100ps

module mipsCpuBus #(
    parameter cpuPkg::word_t resetVector = cpuPkg::ResetVector
) (
    input  logic             clk,
    input  logic             reset,
    output logic             active,
    output cpuPkg::word_t    registerV0,
    output cpuPkg::word_t    address,
    output logic             write,
    output logic             read,
    input  logic             waitrequest,
    output cpuPkg::word_t    writedata,
    output cpuPkg::byteEn_t  byteenable,
    input  cpuPkg::word_t    readdata
);
    import cpuPkg::*;

    decodedCtrl_t ctrl;
    word_t        immExt, rdDataA, rdDataB, aluB, aluResult, loadData, pc, wbData;
    logic [25:0]  jumpIndex;
    logic         aluZero, fetchPhase, decodePhase, memPhase, wbStrobe;

    // Second ALU operand is the immediate or rt
    assign aluB = ctrl.useImm ? immExt : rdDataB;

    cpuControl #(.resetVector(resetVector)) u_control (
        .clk, .reset, .waitrequest, .ctrl, .immExt, .jumpIndex, .rdDataA,
        .aluResult, .aluZero, .loadData, .pc, .fetchPhase, .decodePhase,
        .memPhase, .wbStrobe, .wbData, .active
    );

    instrDecoder u_decoder (
        .clk, .reset, .decodePhase, .readdata, .ctrl, .immExt, .jumpIndex
    );

    regFile u_regs (
        .clk, .reset, .decodePhase,
        .rdAddrA(readdata[25:21]), .rdAddrB(readdata[20:16]),
        .wrEn(wbStrobe), .wrAddr(ctrl.destReg), .wrData(wbData),
        .rdDataA, .rdDataB, .registerV0
    );

    alu u_alu (
        .op(ctrl.aluOp), .a(rdDataA), .b(aluB), .shamt(ctrl.shamt),
        .result(aluResult), .zero(aluZero)
    );

    loadStore u_loadStore (
        .fetchPhase, .memPhase, .ctrl, .pc, .aluResult, .storeData(rdDataB),
        .readdata, .address, .writedata, .loadData, .byteenable, .read, .write
    );

endmodule

// ==== verif/cpuBus_chk.sv ====
`timescale 1ns/100ps

module cpuBusChk (
    input logic            clk,
    input logic            reset,
    input logic            active,
    input cpuPkg::word_t   address,
    input logic            read,
    input logic            write,
    input logic            waitrequest,
    input cpuPkg::word_t   writedata,
    input cpuPkg::byteEn_t byteenable
);

    readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write high together");

    addressAligned: assert property (@(posedge clk) disable iff (reset)
        address[1:0] == 2'b00)
        else $error("address not word aligned");

    // Master holds the request through wait states
    stableOnWait: assert property (@(posedge clk) disable iff (reset)
        (waitrequest && (read || write)) |=> ($stable(address) && $stable(read)
            && $stable(write) && $stable(writedata) && $stable(byteenable)))
        else $error("bus outputs changed during waitrequest");

    staysHalted: assert property (@(posedge clk) disable iff (reset)
        !active |=> !active)
        else $error("active rose again without reset");

endmodule

bind mipsCpuBus cpuBusChk u_chk (.*);

// ==== verif/tbMipsCpuBus.sv ====
`timescale 1ns/100ps

module tbMipsCpuBus;
    import cpuPkg::*;

    localparam int ClkPeriod = 100;
    localparam int CyclesPerProgram = 40 * 5 * 3 + 8;
    localparam int NumPrograms = 13 * 20 + 7 * 20 + 5 + 9 + 14 + 1;
    localparam word_t DataBase = 32'h1000_0000;

    logic    clk = 1'b0;
    logic    reset = 1'b1;
    logic    active;
    logic    write;
    logic    read;
    logic    waitrequest = 1'b1;
    word_t   registerV0;
    word_t   address;
    word_t   writedata;
    word_t   readdata = '0;
    byteEn_t byteenable;

    // Sparse memory keyed by word address
    word_t   mem [word_t];
    word_t   prog [$];
    word_t   wrAddrQ [$];
    word_t   wrDataQ [$];
    byteEn_t wrBeQ [$];
    logic    resetSeen;
    logic    busy = 1'b0;
    int      waits = 0;
    int      errors = 0;
    int      checks = 0;

    mipsCpuBus #(.resetVector(ResetVector)) u_dut (
        .clk, .reset, .active, .registerV0, .address, .write, .read,
        .waitrequest, .writedata, .byteenable, .readdata
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic word_t memRead(word_t a);
        if (mem.exists(a >> 2)) begin
            return mem[a >> 2];
        end
        return a ^ 32'h5A3C_96E1;
    endfunction

    // Bus slave with 0 to 2 random wait states per access
    always @(posedge clk) begin
        resetSeen = reset;
        #1;
        if (resetSeen) begin
            waitrequest = 1'b1;
            busy = 1'b0;
        end else if (read || write) begin
            if (!busy) begin
                busy = 1'b1;
                waits = $urandom % 3;
            end
            if (waits > 0) begin
                waitrequest = 1'b1;
                waits--;
            end else begin
                waitrequest = 1'b0;
                busy = 1'b0;
                if (read) begin
                    readdata = memRead(address);
                end
                if (write) begin
                    wrAddrQ.push_back(address);
                    wrDataQ.push_back(writedata);
                    wrBeQ.push_back(byteenable);
                    mem[address >> 2] = memRead(address);
                    for (int i = 0; i < 4; i++) begin
                        if (byteenable[i]) begin
                            mem[address >> 2][8*i +: 8] = writedata[8*i +: 8];
                        end
                    end
                end
            end
        end else begin
            waitrequest = 1'b0;
        end
    end

    function automatic word_t rType(func_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    shamt_t sh);
        return {opSpecial, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic func_t rFunc(aluOp_t op);
        case (op)
            aluAdd:  return fnAddu;
            aluSub:  return fnSubu;
            aluAnd:  return fnAnd;
            aluOr:   return fnOr;
            aluXor:  return fnXor;
            aluSlt:  return fnSlt;
            aluSltu: return fnSltu;
            aluSll:  return fnSll;
            aluSrl:  return fnSrl;
            aluSra:  return fnSra;
            aluSllv: return fnSllv;
            aluSrlv: return fnSrlv;
            default: return fnSrav;
        endcase
    endfunction

    function automatic opcode_t iOpcode(aluOp_t op);
        case (op)
            aluAnd:  return opAndi;
            aluOr:   return opOri;
            aluXor:  return opXori;
            aluSlt:  return opSlti;
            aluSltu: return opSltiu;
            aluLui:  return opLui;
            default: return opAddiu;
        endcase
    endfunction

    // Expected result straight from the MIPS-I instruction rules
    function automatic word_t refAlu(aluOp_t op, word_t a, word_t b, shamt_t sh);
        word_t r;
        case (op)
            aluAnd:  r = a & b;
            aluOr:   r = a | b;
            aluXor:  r = a ^ b;
            aluAdd:  r = a + b;
            aluSub:  r = a - b;
            aluSlt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: r = (a < b) ? 32'd1 : 32'd0;
            aluSll:  r = b << sh;
            aluSrl:  r = b >> sh;
            aluSra:  r = $signed(b) >>> sh;
            aluSllv: r = b << a[4:0];
            aluSrlv: r = b >> a[4:0];
            aluSrav: r = $signed(b) >>> a[4:0];
            aluLui:  r = {b[15:0], 16'h0000};
            default: r = a;
        endcase
        return r;
    endfunction

    function automatic logic refBranch(branchKind_t k, word_t a, word_t b);
        case (k)
            brEq:    return a == b;
            brNe:    return a != b;
            brLez:   return $signed(a) <= 0;
            brGtz:   return $signed(a) > 0;
            brGez:   return $signed(a) >= 0;
            brLtz:   return $signed(a) < 0;
            default: return 1'b1;
        endcase
    endfunction

    task automatic checkWord(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic checkByteEn(byteEn_t got, byteEn_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL byteenable: got %h expected %h", got, exp);
        end
    endtask

    task automatic checkStore(word_t gotAddr, word_t gotData, word_t expAddr, word_t expData,
                              byteEn_t be);
        word_t mask;
        checks++;
        for (int i = 0; i < 4; i++) begin
            mask[8*i +: 8] = {8{be[i]}};
        end
        if (gotAddr !== expAddr) begin
            errors++;
            $display("FAIL address: got %h expected %h", gotAddr, expAddr);
        end
        if ((gotData & mask) !== (expData & mask)) begin
            errors++;
            $display("FAIL writedata: got %h expected %h", gotData & mask, expData & mask);
        end
    endtask

    task automatic loadConst(regAddr_t r, word_t v);
        prog.push_back(iType(opLui, 5'd0, r, v[31:16]));
        prog.push_back(iType(opOri, r, r, v[15:0]));
    endtask

    // JR $0 with a NOP in its delay slot
    task automatic endProgram();
        prog.push_back(rType(fnJr, 5'd0, 5'd0, 5'd0, 5'd0));
        prog.push_back(32'h0000_0000);
    endtask

    task automatic runProgram();
        int cnt;
        foreach (prog[i]) begin
            mem[(ResetVector >> 2) + word_t'(i)] = prog[i];
        end
        wrAddrQ.delete();
        wrDataQ.delete();
        wrBeQ.delete();
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        checks++;
        if (!active || write || !read) begin
            errors++;
            $display("Bus not in fetch state right after reset");
        end
        checkWord("address", address, ResetVector);
        checkByteEn(byteenable, 4'hF);
        cnt = 0;
        while (active && cnt < CyclesPerProgram) begin
            @(negedge clk);
            cnt++;
        end
        if (active) begin
            errors++;
            $display("Program did not halt within %0d cycles", CyclesPerProgram);
        end
    endtask

    task automatic newProgram();
        prog.delete();
        mem.delete();
    endtask

    task automatic aluCases(aluOp_t op, logic isImm);
        word_t  a;
        word_t  b;
        shamt_t sh;
        imm_t   imm;
        for (int n = 0; n < 20; n++) begin
            a = $urandom;
            b = $urandom;
            sh = shamt_t'($urandom);
            imm = imm_t'($urandom);
            newProgram();
            loadConst(5'd8, a);
            if (isImm) begin
                if (op inside {aluAnd, aluOr, aluXor, aluLui}) begin
                    b = {16'h0000, imm};
                end else begin
                    b = {{16{imm[15]}}, imm};
                end
                prog.push_back(iType(iOpcode(op), (op == aluLui) ? 5'd0 : 5'd8, 5'd2, imm));
            end else begin
                loadConst(5'd9, b);
                prog.push_back(rType(rFunc(op), 5'd8, 5'd9, 5'd2, sh));
            end
            endProgram();
            runProgram();
            checkWord("v0", registerV0, refAlu(op, a, b, sh));
        end
    endtask

    task automatic storeCase(int off, logic isByte);
        word_t   data;
        word_t   expData;
        byteEn_t be;
        data = $urandom;
        be = isByte ? byteEn_t'(4'b0001 << off) : 4'hF;
        // Stored byte belongs in the addressed lane
        expData = isByte ? (word_t'(data[7:0]) << (8 * off)) : data;
        newProgram();
        loadConst(5'd8, DataBase + word_t'(off));
        loadConst(5'd9, data);
        prog.push_back(iType(isByte ? opSb : opSw, 5'd8, 5'd9, 16'h0000));
        endProgram();
        runProgram();
        checks++;
        if (wrAddrQ.size() != 1) begin
            errors++;
            $display("Expected one bus write, saw %0d", wrAddrQ.size());
        end else begin
            checkByteEn(wrBeQ[0], be);
            checkStore(wrAddrQ[0], wrDataQ[0], DataBase, expData, be);
        end
    endtask

    task automatic loadCase(opcode_t op, int off);
        word_t w;
        word_t exp;
        logic [7:0] b;
        w = $urandom;
        b = w[8*off +: 8];
        case (op)
            opLb:    exp = {{24{b[7]}}, b};
            opLbu:   exp = {24'h0, b};
            default: exp = w;
        endcase
        newProgram();
        mem[DataBase >> 2] = w;
        loadConst(5'd8, DataBase + word_t'(off));
        prog.push_back(iType(op, 5'd8, 5'd2, 16'h0000));
        endProgram();
        runProgram();
        checkWord("v0", registerV0, exp);
    endtask

    // Branch at index 5 targets index 8; index 6 is the delay slot
    task automatic branchCase(branchKind_t k, word_t a, word_t b);
        word_t tgt;
        tgt = ResetVector + 32'd32;
        newProgram();
        loadConst(5'd8, a);
        loadConst(5'd9, (k == brJumpReg) ? tgt : b);
        prog.push_back(iType(opOri, 5'd0, 5'd2, 16'h0001));
        case (k)
            brEq:    prog.push_back(iType(opBeq, 5'd8, 5'd9, 16'd2));
            brNe:    prog.push_back(iType(opBne, 5'd8, 5'd9, 16'd2));
            brLez:   prog.push_back(iType(opBlez, 5'd8, 5'd0, 16'd2));
            brGtz:   prog.push_back(iType(opBgtz, 5'd8, 5'd0, 16'd2));
            brGez:   prog.push_back(iType(opRegimm, 5'd8, regAddr_t'(rtBgez), 16'd2));
            brLtz:   prog.push_back(iType(opRegimm, 5'd8, regAddr_t'(rtBltz), 16'd2));
            brJump:  prog.push_back({opJ, tgt[27:2]});
            default: prog.push_back(rType(fnJr, 5'd9, 5'd0, 5'd0, 5'd0));
        endcase
        prog.push_back(iType(opOri, 5'd2, 5'd2, 16'h0002));
        prog.push_back(iType(opOri, 5'd2, 5'd2, 16'h0004));
        prog.push_back(iType(opOri, 5'd2, 5'd2, 16'h0008));
        endProgram();
        runProgram();
        checkWord("v0", registerV0, refBranch(k, a, b) ? 32'd11 : 32'd15);
    endtask

    task automatic haltCase();
        newProgram();
        prog.push_back(iType(opOri, 5'd0, 5'd2, 16'h0055));
        endProgram();
        runProgram();
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (read || write || active) begin
                errors++;
                $display("Bus activity or active seen after halt");
            end
        end
        checkWord("v0", registerV0, 32'h0000_0055);
    endtask

    initial begin
        #(NumPrograms * CyclesPerProgram * ClkPeriod);
        $display("Watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        aluOp_t      rOps [13];
        aluOp_t      iOps [7];
        branchKind_t kinds [6];
        word_t       a;
        rOps = '{aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSltu,
                 aluSll, aluSrl, aluSra, aluSllv, aluSrlv, aluSrav};
        iOps = '{aluAdd, aluAnd, aluOr, aluXor, aluSlt, aluSltu, aluLui};
        kinds = '{brEq, brNe, brLez, brGtz, brGez, brLtz};
        void'($urandom(38952));
        foreach (rOps[i]) aluCases(rOps[i], 1'b0);
        foreach (iOps[i]) aluCases(iOps[i], 1'b1);
        for (int off = 0; off < 4; off++) begin
            storeCase(off, 1'b1);
            loadCase(opLb, off);
            loadCase(opLbu, off);
        end
        storeCase(0, 1'b0);
        loadCase(opLw, 0);
        foreach (kinds[i]) begin
            for (int t = 0; t < 2; t++) begin
                a = $urandom;
                a[31] = (t == 0);
                branchCase(kinds[i], a, (t == 0) ? a : a + 32'd1);
            end
        end
        branchCase(brJump, 32'd0, 32'd0);
        branchCase(brJumpReg, 32'd0, 32'd0);
        haltCase();
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
hw/cpuPkg.sv
hw/regFile.sv
hw/alu.sv
hw/instrDecoder.sv
hw/loadStore.sv
hw/cpuControl.sv
hw/mipsCpuBus.sv
verif/cpuBus_chk.sv
verif/tbMipsCpuBus.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tbMipsCpuBus
FLIST     ?= flist.f
PASS_MSG  := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
